/* compile.f */
+incdir+design
+incdir+verif
design/dma_pkg.sv
design/dma_regs.sv
design/dma_engine.sv
design/dma_mem_port.sv
design/dma_subsystem.sv
verif/dma_tb.sv

/* design/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// host byte addresses of the four DMA registers
`define DMA_SRC_ADDR   32'h3000_002C
`define DMA_DST_ADDR   32'h3000_0030
`define DMA_LEN_ADDR   32'h3000_0034
`define DMA_CTRL_ADDR  32'h3000_0038

// the on-chip memory occupies everything from this address upwards
`define DMA_MEM_BASE   32'h4000_0000
`define DMA_MEM_WORDS  256

// control register bits, start bits clear themselves after one cycle
`define DMA_CTRL_COPY_BIT  0
`define DMA_CTRL_FILL_BIT  1
`define DMA_CTRL_BUSY_BIT  2
`define DMA_CTRL_DONE_BIT  3

`endif

/* design/dma_engine.sv */
`timescale 1ns/1ps

module dma_engine (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  dma_pkg::dma_op_t  op,
    input  dma_pkg::word_t    src_addr,
    input  dma_pkg::word_t    dst_addr,
    input  dma_pkg::word_t    len,
    input  dma_pkg::word_t    mem_rdata,
    input  logic              mem_ack,
    output logic              busy,
    output logic              done,
    output dma_pkg::word_t    src_next,
    output dma_pkg::word_t    dst_next,
    output logic              addr_update,
    output logic              mem_req,
    output logic              mem_we,
    output dma_pkg::word_t    mem_addr,
    output dma_pkg::word_t    mem_wdata
);

    dma_pkg::dma_state_t state;
    dma_pkg::word_t      src_ptr;
    dma_pkg::word_t      dst_ptr;
    dma_pkg::word_t      cnt;
    dma_pkg::word_t      data_q;

    assign busy     = (state != dma_pkg::st_idle);
    assign src_next = src_ptr;
    assign dst_next = dst_ptr;

    // no request once the counter is exhausted, the state then winds down
    assign mem_req  = busy && (cnt != '0);
    assign mem_we   = (state == dma_pkg::st_write) || (state == dma_pkg::st_fill);
    assign mem_addr = (state == dma_pkg::st_write) ? dst_ptr : src_ptr;

    // for a fill the destination register carries the pattern
    assign mem_wdata = (state == dma_pkg::st_fill) ? dst_ptr : data_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= dma_pkg::st_idle;
            done        <= 1'b0;
            addr_update <= 1'b0;
        end else begin
            done        <= 1'b0;
            addr_update <= 1'b0;
            case (state)
                dma_pkg::st_idle: begin
                    if (start) begin
                        case (op)
                            dma_pkg::op_copy: state <= dma_pkg::st_read;
                            dma_pkg::op_fill: state <= dma_pkg::st_fill;
                            default:          state <= dma_pkg::st_idle;
                        endcase
                    end
                end
                dma_pkg::st_read: begin
                    if (cnt == '0) begin
                        state <= dma_pkg::st_idle;
                        done  <= 1'b1;
                    end else if (mem_ack) begin
                        state <= dma_pkg::st_write;
                    end
                end
                dma_pkg::st_write: begin
                    // one word is complete, go back and check the counter
                    if (mem_ack) begin
                        state       <= dma_pkg::st_read;
                        addr_update <= 1'b1;
                    end
                end
                dma_pkg::st_fill: begin
                    if (cnt == '0) begin
                        state <= dma_pkg::st_idle;
                        done  <= 1'b1;
                    end else if (mem_ack) begin
                        addr_update <= 1'b1;
                    end
                end
                default: begin
                    state <= dma_pkg::st_idle;
                end
            endcase
        end
    end

    // pointers, counter and the copied word
    always_ff @(posedge clk) begin
        if ((state == dma_pkg::st_idle) && start) begin
            src_ptr <= src_addr;
            dst_ptr <= dst_addr;
            cnt     <= len;
        end
        if (mem_ack && (state == dma_pkg::st_read)) begin
            data_q <= mem_rdata;
        end
        if (mem_ack && (state == dma_pkg::st_write)) begin
            src_ptr <= src_ptr + 32'd4;
            dst_ptr <= dst_ptr + 32'd4;
            cnt     <= cnt - 32'd1;
        end
        if (mem_ack && (state == dma_pkg::st_fill)) begin
            src_ptr <= src_ptr + 32'd4;
            cnt     <= cnt - 32'd1;
        end
    end

endmodule

/* design/dma_mem_port.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_mem_port (
    input  logic            clk,
    input  logic            resetn,
    input  logic            host_req,
    input  logic            host_we,
    input  dma_pkg::word_t  host_addr,
    input  dma_pkg::word_t  host_wdata,
    input  logic            busy,
    input  logic            mem_req,
    input  logic            mem_we,
    input  dma_pkg::word_t  mem_addr,
    input  dma_pkg::word_t  mem_wdata,
    output dma_pkg::word_t  host_rdata,
    output logic            host_ack,
    output dma_pkg::word_t  mem_rdata,
    output logic            mem_ack
);

    localparam int IDX_W = $clog2(`DMA_MEM_WORDS);

    dma_pkg::word_t mem [`DMA_MEM_WORDS];

    dma_pkg::word_t host_off;
    dma_pkg::word_t eng_off;
    logic [IDX_W-1:0] host_idx;
    logic [IDX_W-1:0] eng_idx;
    logic eng_go;
    logic host_go;

    // both sides present full bus addresses, the array is word indexed
    assign host_off = host_addr - `DMA_MEM_BASE;
    assign eng_off  = mem_addr - `DMA_MEM_BASE;
    assign host_idx = host_off[IDX_W+1:2];
    assign eng_idx  = eng_off[IDX_W+1:2];

    // a request still high in its ack cycle is the same request
    assign eng_go  = mem_req && !mem_ack;

    // the host waits out a whole transfer, not just single engine cycles
    assign host_go = host_req && !host_ack && !busy && !eng_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_ack  <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            mem_ack  <= eng_go;
            host_ack <= host_go;
        end
    end

    always_ff @(posedge clk) begin
        if (eng_go) begin
            if (mem_we) begin
                mem[eng_idx] <= mem_wdata;
            end
        end else if (host_go) begin
            if (host_we) begin
                mem[host_idx] <= host_wdata;
            end
        end
    end

    // read data comes back with the ack, old contents on a write
    always_ff @(posedge clk) begin
        if (eng_go) begin
            mem_rdata <= mem[eng_idx];
        end
        if (host_go) begin
            host_rdata <= mem[host_idx];
        end
    end

endmodule

/* design/dma_pkg.sv */
package dma_pkg;

    // data words and byte addresses share one 32-bit type
    typedef logic [31:0] word_t;

    // operation requested through the control register
    // copy takes precedence when both start bits are written together
    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_copy = 2'd1,
        op_fill = 2'd2
    } dma_op_t;

    // transfer engine states
    // st_read and st_write alternate for a copy, st_fill repeats for a fill
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_read  = 2'd1,
        st_write = 2'd2,
        st_fill  = 2'd3
    } dma_state_t;

endpackage

/* design/dma_regs.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_regs (
    input  logic              clk,
    input  logic              resetn,
    input  dma_pkg::word_t    addr,
    input  logic [3:0]        wstrb,
    input  dma_pkg::word_t    wdata,
    input  logic              sel,
    input  logic              valid,
    input  logic              busy,
    input  logic              done,
    input  dma_pkg::word_t    src_next,
    input  dma_pkg::word_t    dst_next,
    input  logic              addr_update,
    output dma_pkg::word_t    rdata,
    output logic              ready,
    output dma_pkg::word_t    src_addr,
    output dma_pkg::word_t    dst_addr,
    output dma_pkg::word_t    len,
    output logic              start,
    output dma_pkg::dma_op_t  op
);

    logic [1:0]     ctrl_bits;
    logic           done_flag;
    logic           pending;
    logic           access;
    logic           wr;
    dma_pkg::word_t status;
    dma_pkg::word_t rd_value;

    // an access is taken once, the ready cycle blocks a second capture
    assign access  = sel && valid && !ready;
    assign wr      = access && (wstrb != 4'b0000);

    // start bits written but not yet seen by the engine as busy
    assign pending = start || (ctrl_bits != 2'b00);

    // a pending start already reads as busy so a poll cannot see stale done
    always_comb begin
        status = '0;
        status[`DMA_CTRL_COPY_BIT] = ctrl_bits[0];
        status[`DMA_CTRL_FILL_BIT] = ctrl_bits[1];
        status[`DMA_CTRL_BUSY_BIT] = busy || pending;
        status[`DMA_CTRL_DONE_BIT] = (done_flag || done) && !pending;
    end

    always_comb begin
        case (addr)
            `DMA_SRC_ADDR:  rd_value = src_addr;
            `DMA_DST_ADDR:  rd_value = dst_addr;
            `DMA_LEN_ADDR:  rd_value = len;
            `DMA_CTRL_ADDR: rd_value = status;
            default:        rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready <= 1'b0;
        end else begin
            ready <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata <= rd_value;
        end
    end

    // the engine writes its advanced pointers back after every word
    always_ff @(posedge clk) begin
        if (!resetn) begin
            src_addr <= '0;
            dst_addr <= '0;
            len      <= '0;
        end else if (addr_update) begin
            src_addr <= src_next;
            dst_addr <= dst_next;
        end else if (wr && !busy) begin
            case (addr)
                `DMA_SRC_ADDR: src_addr <= wdata;
                `DMA_DST_ADDR: dst_addr <= wdata;
                `DMA_LEN_ADDR: len      <= wdata;
                default:       len      <= len;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ctrl_bits <= 2'b00;
            start     <= 1'b0;
            op        <= dma_pkg::op_none;
            done_flag <= 1'b0;
        end else begin
            start <= 1'b0;
            if (ctrl_bits != 2'b00) begin
                // bits are held through the ack cycle, then turned into a pulse
                start     <= 1'b1;
                op        <= ctrl_bits[0] ? dma_pkg::op_copy : dma_pkg::op_fill;
                ctrl_bits <= 2'b00;
            end else if (wr && (addr == `DMA_CTRL_ADDR)) begin
                ctrl_bits <= {wdata[`DMA_CTRL_FILL_BIT], wdata[`DMA_CTRL_COPY_BIT]};
            end
            if (start) begin
                done_flag <= 1'b0;
            end
            if (done) begin
                done_flag <= 1'b1;
            end
        end
    end

endmodule

/* design/dma_subsystem.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_subsystem (
    input  logic            clk,
    input  logic            resetn,
    input  dma_pkg::word_t  addr,
    input  logic [3:0]      wstrb,
    input  dma_pkg::word_t  wdata,
    input  logic            valid,
    output dma_pkg::word_t  rdata,
    output logic            ready
);

    logic             mem_sel;
    logic             reg_sel;
    logic             host_req;
    logic             host_we;
    logic             mem_hold;
    logic             reg_ready;
    logic             host_ack;
    dma_pkg::word_t   reg_rdata;
    dma_pkg::word_t   host_rdata;

    dma_pkg::word_t   src_addr;
    dma_pkg::word_t   dst_addr;
    dma_pkg::word_t   len;
    logic             start;
    dma_pkg::dma_op_t op;
    logic             eng_busy;
    logic             eng_done;
    dma_pkg::word_t   src_next;
    dma_pkg::word_t   dst_next;
    logic             addr_update;

    logic             mem_req;
    logic             mem_we;
    dma_pkg::word_t   mem_addr;
    dma_pkg::word_t   mem_wdata;
    dma_pkg::word_t   mem_rdata;
    logic             mem_ack;

    // memory sits above the base address, the register page below it
    assign mem_sel  = (addr >= `DMA_MEM_BASE);
    assign reg_sel  = !mem_sel;
    assign host_req = valid && mem_sel;
    assign host_we  = (wstrb != 4'b0000);

    // the start pulse comes a cycle before busy and must already hold the host off
    assign mem_hold = eng_busy || start;

    assign ready = reg_ready || host_ack;
    assign rdata = host_ack ? host_rdata : reg_rdata;

    dma_regs u_dma_regs (
        .clk         (clk),
        .resetn      (resetn),
        .addr        (addr),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .sel         (reg_sel),
        .valid       (valid),
        .busy        (eng_busy),
        .done        (eng_done),
        .src_next    (src_next),
        .dst_next    (dst_next),
        .addr_update (addr_update),
        .rdata       (reg_rdata),
        .ready       (reg_ready),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .len         (len),
        .start       (start),
        .op          (op)
    );

    dma_engine u_dma_engine (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .op          (op),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .len         (len),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack),
        .busy        (eng_busy),
        .done        (eng_done),
        .src_next    (src_next),
        .dst_next    (dst_next),
        .addr_update (addr_update),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    dma_mem_port u_dma_mem_port (
        .clk        (clk),
        .resetn     (resetn),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (addr),
        .host_wdata (wdata),
        .busy       (mem_hold),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .host_rdata (host_rdata),
        .host_ack   (host_ack),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the DMA testbench with Verilator and runs it
# the script exits with the status of the step that went wrong
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dma_tb -f compile.f -o dma_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build returned status $status"
    exit "$status"
fi

./obj_dir/dma_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation run returned status $status"
    exit "$status"
fi

echo "simulation run returned status 0"
exit 0

/* verif/dma_tb_cases.svh */
`ifndef DMA_TB_CASES_SVH
`define DMA_TB_CASES_SVH

// columns: start bits written to control, source word index, destination word index,
// length in words and fill pattern
// start bits 2'b01 run a copy, 2'b10 a fill, and 2'b11 must still run a copy
// a fill writes over the source range and the pattern goes into the destination register

task automatic load_cases();
    //       bits   src  dst  len  pattern
    add_case(2'b01,   0,  64,   8, 32'h0000_0000);
    add_case(2'b01,  16, 128,   1, 32'h0000_0000);
    add_case(2'b10, 200,   0,  12, 32'hA5A5_5A5A);

    // zero length copy and fill leave the memory alone
    add_case(2'b01,  30,  90,   0, 32'h0000_0000);
    add_case(2'b10,  40,   0,   0, 32'h0F0F_F0F0);

    // overlapping ranges, forward then backward
    add_case(2'b01, 100, 102,  10, 32'h0000_0000);
    add_case(2'b01, 150, 148,   6, 32'h0000_0000);

    // both start bits
    add_case(2'b11,  70,  10,   5, 32'h0000_0000);

    add_case(2'b10,   0,   0,   4, 32'h1234_5678);
    add_case(2'b01, 240, 220,  16, 32'h0000_0000);
    add_case(2'b01,  32, 160,  32, 32'h0000_0000);

    // fill that runs up to the last memory word
    add_case(2'b10, 250,   0,   6, 32'hFFFF_0000);

    // copy whose last destination word is read by the host straight after the start
    busy_read_case = make_case(2'b01, 0, 180, 6, 32'h0000_0000);
endtask

`endif

/* verif/dma_tb.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_tb;

    localparam int IDX_W = $clog2(`DMA_MEM_WORDS);

    typedef logic [IDX_W-1:0] idx_t;

    typedef struct packed {
        logic [1:0]     start_bits;
        int             src_idx;
        int             dst_idx;
        int             len;
        dma_pkg::word_t pattern;
    } tb_case_t;

    logic           clk;
    logic           resetn;
    dma_pkg::word_t addr;
    logic [3:0]     wstrb;
    dma_pkg::word_t wdata;
    logic           valid;
    dma_pkg::word_t rdata;
    logic           ready;

    // mirror of the DUT memory that follows each transfer as a sequential ascending one
    dma_pkg::word_t model_mem [`DMA_MEM_WORDS];
    tb_case_t       cases[$];
    tb_case_t       busy_read_case;
    int             cycle_count;
    int             cycle_limit;

    dma_subsystem u_dma_subsystem (
        .clk    (clk),
        .resetn (resetn),
        .addr   (addr),
        .wstrb  (wstrb),
        .wdata  (wdata),
        .valid  (valid),
        .rdata  (rdata),
        .ready  (ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic tb_case_t make_case(input logic [1:0] start_bits, input int src_idx,
                                           input int dst_idx, input int len,
                                           input dma_pkg::word_t pattern);
        tb_case_t c;
        c.start_bits = start_bits;
        c.src_idx    = src_idx;
        c.dst_idx    = dst_idx;
        c.len        = len;
        c.pattern    = pattern;
        return c;
    endfunction

    task automatic add_case(input logic [1:0] start_bits, input int src_idx, input int dst_idx,
                            input int len, input dma_pkg::word_t pattern);
        cases.push_back(make_case(start_bits, src_idx, dst_idx, len, pattern));
    endtask

    `include "dma_tb_cases.svh"

    function automatic dma_pkg::word_t word_address(input int idx);
        return `DMA_MEM_BASE + 32'(4 * idx);
    endfunction

    // transfer, polling, window reads and pointer reads of one case
    function automatic int case_cycles(input tb_case_t c);
        return 4 * c.len + 64 + 3 * (c.len + 4);
    endfunction

    function automatic int compute_limit();
        int total;
        // reset, memory setup with its read back and the register tests
        total = 8 + 6 * `DMA_MEM_WORDS + 64;
        foreach (cases[i]) begin
            total += case_cycles(cases[i]);
        end
        total += case_cycles(busy_read_case);
        return total + 200;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_word(input dma_pkg::word_t got, input dma_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_status(input dma_pkg::word_t got, input dma_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: status %08h (busy %0b done %0b), expected %08h",
                                   what, got, got[`DMA_CTRL_BUSY_BIT],
                                   got[`DMA_CTRL_DONE_BIT], exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s: ready after %0d cycles, expected %0d", what, got, exp));
        end
    endtask

    // inputs change on the falling edge and ready and rdata are sampled there too
    task automatic bus_write(input dma_pkg::word_t a, input dma_pkg::word_t d, output int lat);
        @(negedge clk);
        addr  = a;
        wdata = d;
        wstrb = 4'hF;
        valid = 1'b1;
        lat   = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ready);
        valid = 1'b0;
        wstrb = 4'h0;
    endtask

    task automatic bus_read(input dma_pkg::word_t a, output dma_pkg::word_t d, output int lat);
        @(negedge clk);
        addr  = a;
        wstrb = 4'h0;
        valid = 1'b1;
        lat   = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ready);
        d     = rdata;
        valid = 1'b0;
    endtask

    task automatic reg_write(input dma_pkg::word_t a, input dma_pkg::word_t d);
        int lat;
        bus_write(a, d, lat);
        check_latency(lat, 1, $sformatf("register write %08h", a));
    endtask

    task automatic reg_read(input dma_pkg::word_t a, output dma_pkg::word_t d);
        int lat;
        bus_read(a, d, lat);
        check_latency(lat, 1, $sformatf("register read %08h", a));
    endtask

    task automatic mem_write(input int idx, input dma_pkg::word_t d);
        int lat;
        bus_write(word_address(idx), d, lat);
        check_latency(lat, 1, $sformatf("memory write of word %0d", idx));
    endtask

    task automatic mem_read(input int idx, output dma_pkg::word_t d);
        int lat;
        bus_read(word_address(idx), d, lat);
        check_latency(lat, 1, $sformatf("memory read of word %0d", idx));
    endtask

    // copy wins when both start bits are set
    task automatic apply_model(input tb_case_t c);
        for (int i = 0; i < c.len; i++) begin
            if (c.start_bits[0]) begin
                model_mem[idx_t'(c.dst_idx + i)] = model_mem[idx_t'(c.src_idx + i)];
            end else begin
                model_mem[idx_t'(c.src_idx + i)] = c.pattern;
            end
        end
    endtask

    task automatic start_transfer(input tb_case_t c);
        dma_pkg::word_t dst_reg;
        if (c.start_bits[0]) begin
            dst_reg = word_address(c.dst_idx);
        end else begin
            dst_reg = c.pattern;
        end
        reg_write(`DMA_SRC_ADDR, word_address(c.src_idx));
        reg_write(`DMA_DST_ADDR, dst_reg);
        reg_write(`DMA_LEN_ADDR, c.len);
        reg_write(`DMA_CTRL_ADDR, {30'd0, c.start_bits});
    endtask

    task automatic wait_done(output dma_pkg::word_t status);
        dma_pkg::word_t st;
        do begin
            reg_read(`DMA_CTRL_ADDR, st);
        end while (st[`DMA_CTRL_BUSY_BIT] || !st[`DMA_CTRL_DONE_BIT]);
        status = st;
    endtask

    task automatic check_result(input tb_case_t c, input string tag);
        dma_pkg::word_t status;
        dma_pkg::word_t done_only;
        dma_pkg::word_t got;
        dma_pkg::word_t exp_dst;
        int first;
        int lo;
        int hi;
        done_only = '0;
        done_only[`DMA_CTRL_DONE_BIT] = 1'b1;
        wait_done(status);
        check_status(status, done_only, {tag, " final status"});

        // target range plus two words on each side
        first = c.start_bits[0] ? c.dst_idx : c.src_idx;
        lo = (first - 2 < 0) ? 0 : first - 2;
        hi = (first + c.len + 1 > `DMA_MEM_WORDS - 1) ? `DMA_MEM_WORDS - 1 : first + c.len + 1;
        for (int i = lo; i <= hi; i++) begin
            mem_read(i, got);
            check_word(got, model_mem[idx_t'(i)], $sformatf("%s memory word %0d", tag, i));
        end

        exp_dst = c.start_bits[0] ? word_address(c.dst_idx + c.len) : c.pattern;
        reg_read(`DMA_SRC_ADDR, got);
        check_word(got, word_address(c.src_idx + c.len), {tag, " source register"});
        reg_read(`DMA_DST_ADDR, got);
        check_word(got, exp_dst, {tag, " destination register"});
    endtask

    initial begin
        dma_pkg::word_t got;
        int lat;
        clk         = 1'b0;
        resetn      = 1'b0;
        addr        = '0;
        wstrb       = 4'h0;
        wdata       = '0;
        valid       = 1'b0;
        cycle_count = 0;
        void'($urandom(32'h23f6d22c));
        load_cases();
        cycle_limit = compute_limit();

        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        reg_read(`DMA_SRC_ADDR, got);
        check_word(got, '0, "source register after reset");
        reg_read(`DMA_DST_ADDR, got);
        check_word(got, '0, "destination register after reset");
        reg_read(`DMA_LEN_ADDR, got);
        check_word(got, '0, "length register after reset");
        reg_read(`DMA_CTRL_ADDR, got);
        check_status(got, '0, "control register after reset");
        reg_read(`DMA_SRC_ADDR - 32'd4, got);
        check_word(got, '0, "unmapped register");

        reg_write(`DMA_SRC_ADDR, 32'h4000_0010);
        reg_write(`DMA_DST_ADDR, 32'h4000_0020);
        reg_write(`DMA_LEN_ADDR, 32'd7);
        reg_read(`DMA_SRC_ADDR, got);
        check_word(got, 32'h4000_0010, "source register read back");
        reg_read(`DMA_DST_ADDR, got);
        check_word(got, 32'h4000_0020, "destination register read back");
        reg_read(`DMA_LEN_ADDR, got);
        check_word(got, 32'd7, "length register read back");

        for (int i = 0; i < `DMA_MEM_WORDS; i++) begin
            model_mem[idx_t'(i)] = $urandom();
            mem_write(i, model_mem[idx_t'(i)]);
        end
        for (int i = 0; i < `DMA_MEM_WORDS; i++) begin
            mem_read(i, got);
            check_word(got, model_mem[idx_t'(i)], $sformatf("memory read back word %0d", i));
        end

        foreach (cases[i]) begin
            start_transfer(cases[i]);
            apply_model(cases[i]);
            check_result(cases[i], $sformatf("case %0d", i));
        end

        // the read has to wait out the whole copy and then see its result
        start_transfer(busy_read_case);
        apply_model(busy_read_case);
        bus_read(word_address(busy_read_case.dst_idx + busy_read_case.len - 1), got, lat);
        check_word(got, model_mem[idx_t'(busy_read_case.dst_idx + busy_read_case.len - 1)],
                   "host read held behind a copy");
        if (lat < 4 * busy_read_case.len) begin
            report_error($sformatf("host read acknowledged after %0d cycles inside the copy",
                                   lat));
        end
        check_result(busy_read_case, "held read case");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
